// File: logic/aes_params.svh
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// Number of cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// Width of both the block and the key
`define AES_BLOCK_BITS 128

`endif

// File: logic/aesStatePkg.sv
`include "aes_params.svh"

package aesStatePkg;

    typedef logic [7:0] aesByteT;

    // Four bytes of one column with row 0 in the high bits
    typedef aesByteT [0:3] aesColumnT;

    // Byte view for SubBytes and ShiftRows, column view for mixing and keys.
    // Byte 4*c+r sits in column c, row r
    typedef union packed {
        aesByteT   [0:`AES_BLOCK_BITS/8-1]  bytes;
        aesColumnT [0:`AES_BLOCK_BITS/32-1] cols;
    } aesBlockT;

    // Multiply by x in GF(2^8) with reduction by x^8+x^4+x^3+x+1
    function automatic aesByteT gfDouble(aesByteT value);
        aesByteT shifted;
        shifted = {value[6:0], 1'b0};
        if (value[7])
        begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage

// File: logic/aesKeyPkg.sv
`include "aes_params.svh"

package aesKeyPkg;

    import aesStatePkg::*;

    // Round key as four words w0..w3 with w0 in the high bits
    typedef aesColumnT [0:`AES_BLOCK_BITS/32-1] aesRoundKeyT;

    // Round constant byte that heads an otherwise zero word
    typedef logic [7:0] aesRconT;

    // Round index 0..10
    typedef logic [3:0] aesRoundNumT;

    // Rcon used for the first expansion step
    localparam aesRconT RCON_FIRST = 8'h01;

    // Position of the rcon byte inside a word
    function automatic aesColumnT rconWord(aesRconT rcon);
        return {rcon, 8'h00, 8'h00, 8'h00};
    endfunction

endpackage

// File: logic/aesKeyIf.sv
`timescale 1ns/1ns

interface aesKeyIf
    import aesKeyPkg::*;
();

    logic        load;
    logic        advance;
    aesRoundKeyT cipherKey;
    aesRoundKeyT roundKey;

    modport ctrl (
        output load,
        output advance,
        output cipherKey,
        input  roundKey
    );

    modport sched (
        input  load,
        input  advance,
        input  cipherKey,
        output roundKey
    );

endinterface

// File: logic/aesSbox.sv
`timescale 1ns/1ns

module aesSbox
    import aesStatePkg::*;
(
    input  aesByteT inByte,
    output aesByteT outByte
);

    // Forward S-box, indexed by the input byte
    localparam aesByteT SBOX_TABLE [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    assign outByte = SBOX_TABLE[inByte];

endmodule

// File: logic/mixColumns.sv
`timescale 1ns/1ns

module mixColumns
    import aesStatePkg::*;
(
    input  aesBlockT inState,
    output aesBlockT outState
);

    // Multiply by 3 as 2*b + b
    function automatic aesByteT gfTriple(aesByteT value);
        return gfDouble(value) ^ value;
    endfunction

    // One column times the circulant matrix
    // [2 3 1 1; 1 2 3 1; 1 1 2 3; 3 1 1 2]
    function automatic aesColumnT mixColumn(aesColumnT col);
        aesColumnT mixed;
        mixed[0] = gfDouble(col[0]) ^ gfTriple(col[1]) ^ col[2] ^ col[3];
        mixed[1] = col[0] ^ gfDouble(col[1]) ^ gfTriple(col[2]) ^ col[3];
        mixed[2] = col[0] ^ col[1] ^ gfDouble(col[2]) ^ gfTriple(col[3]);
        mixed[3] = gfTriple(col[0]) ^ col[1] ^ col[2] ^ gfDouble(col[3]);
        return mixed;
    endfunction

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            outState.cols[c] = mixColumn(inState.cols[c]);
        end
    end

endmodule

// File: logic/aesRoundPath.sv
`timescale 1ns/1ns

module aesRoundPath
    import aesStatePkg::*;
(
    input  aesBlockT state,
    input  logic     finalRound,
    output aesBlockT roundOut
);

    aesByteT  subBytes [16];
    aesBlockT subState;
    aesBlockT shiftState;
    aesBlockT mixState;

    // SubBytes, one lookup per byte
    for (genvar i = 0; i < 16; i++)
    begin : gSub
        aesSbox sbox (
            .inByte (state.bytes[i]),
            .outByte(subBytes[i])
        );
    end

    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            subState.bytes[i] = subBytes[i];
        end
    end

    // ShiftRows moves row r left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shiftState.bytes[4*c+r] = subState.bytes[4*((c+r)%4)+r];
            end
        end
    end

    mixColumns mixer (
        .inState (shiftState),
        .outState(mixState)
    );

    // Last round has no MixColumns
    assign roundOut = finalRound ? shiftState : mixState;

endmodule

// File: logic/aesKeySchedule.sv
`timescale 1ns/1ns

module aesKeySchedule
    import aesStatePkg::*;
    import aesKeyPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    aesKeyIf.sched keyPort
);

    aesRoundKeyT roundKeyReg;
    aesRconT     rconReg;
    aesRoundKeyT srcKey;
    aesRconT     srcRcon;
    aesColumnT   rotWord;
    aesByteT     subWord [4];
    aesColumnT   tempWord;
    aesRoundKeyT nextKey;

    // Load starts from the cipher key, advance from the held round key
    assign srcKey  = keyPort.load ? keyPort.cipherKey : roundKeyReg;
    assign srcRcon = keyPort.load ? RCON_FIRST : aesRconT'(gfDouble(rconReg));

    // RotWord on the last word
    assign rotWord = {srcKey[3][1], srcKey[3][2], srcKey[3][3], srcKey[3][0]};

    for (genvar i = 0; i < 4; i++)
    begin : gSubWord
        aesSbox sbox (
            .inByte (rotWord[i]),
            .outByte(subWord[i])
        );
    end

    assign tempWord = {subWord[0], subWord[1], subWord[2], subWord[3]} ^ rconWord(srcRcon);

    // XOR chain across the four words
    always_comb
    begin
        nextKey[0] = srcKey[0] ^ tempWord;
        for (int i = 1; i < 4; i++)
        begin
            nextKey[i] = srcKey[i] ^ nextKey[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (keyPort.load || keyPort.advance)
        begin
            roundKeyReg <= nextKey;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rconReg <= '0;
        end
        else if (keyPort.load || keyPort.advance)
        begin
            rconReg <= srcRcon;
        end
    end

    assign keyPort.roundKey = roundKeyReg;

    // Both pulses come from the state unit FSM
    loadAdvanceExclusive: assert property (
        @(posedge clk) disable iff (rst) !(keyPort.load && keyPort.advance)
    );

endmodule

// File: logic/aesStateUnit.sv
`timescale 1ns/1ns

`include "aes_params.svh"

module aesStateUnit
    import aesStatePkg::*;
    import aesKeyPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  aesBlockT plainText,
    input  aesBlockT cipherKey,
    input  logic     outReady,
    input  aesBlockT roundOut,
    output logic     inReady,
    output logic     outValid,
    output aesBlockT cipherText,
    output aesBlockT state,
    output logic     finalRound,
    aesKeyIf.ctrl    keyPort
);

    aesBlockT    stateReg;
    aesBlockT    keyedRound;
    aesRoundNumT roundNum;
    logic        busy;
    logic        outValidReg;
    logic        accept;

    // Idle means no rounds running and no result waiting
    assign inReady    = !busy && (!outValidReg || outReady);
    assign accept     = inValid && inReady;
    assign finalRound = (roundNum == aesRoundNumT'(`AES_ROUNDS));

    // Key schedule control
    assign keyPort.load      = accept;
    assign keyPort.advance   = busy && !finalRound;
    assign keyPort.cipherKey = aesRoundKeyT'(cipherKey);

    // AddRoundKey on the round path result
    assign keyedRound = aesBlockT'(roundOut ^ aesBlockT'(keyPort.roundKey));

    // Initial AddRoundKey on accept, one full round per cycle after that
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            stateReg <= aesBlockT'(plainText ^ cipherKey);
        end
        else if (busy)
        begin
            stateReg <= keyedRound;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy        <= 1'b0;
            roundNum    <= '0;
            outValidReg <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                busy     <= 1'b1;
                roundNum <= aesRoundNumT'(1);
            end
            else if (busy)
            begin
                if (finalRound)
                begin
                    busy     <= 1'b0;
                    roundNum <= '0;
                end
                else
                begin
                    roundNum <= roundNum + aesRoundNumT'(1);
                end
            end

            // Result valid after the last round, held until taken
            if (busy && finalRound)
            begin
                outValidReg <= 1'b1;
            end
            else if (outReady)
            begin
                outValidReg <= 1'b0;
            end
        end
    end

    assign state      = stateReg;
    assign cipherText = stateReg;
    assign outValid   = outValidReg;

    // Result must not change or vanish while the sink stalls
    outputHeld: assert property (
        @(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(cipherText)
    );

    // Each key step follows the load or an earlier step of the same block
    advanceWhileBusy: assert property (
        @(posedge clk) disable iff (rst)
        keyPort.advance |-> $past(keyPort.load || keyPort.advance)
    );

endmodule

// File: logic/aesCipherTop.sv
`timescale 1ns/1ns

module aesCipherTop
    import aesStatePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  aesBlockT plainText,
    input  aesBlockT cipherKey,
    input  logic     outReady,
    output logic     inReady,
    output logic     outValid,
    output aesBlockT cipherText
);

    aesBlockT state;
    aesBlockT roundOut;
    logic     finalRound;

    aesKeyIf keyBus ();

    // Control, state register and AddRoundKey
    aesStateUnit stateUnit (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .plainText (plainText),
        .cipherKey (cipherKey),
        .outReady  (outReady),
        .roundOut  (roundOut),
        .inReady   (inReady),
        .outValid  (outValid),
        .cipherText(cipherText),
        .state     (state),
        .finalRound(finalRound),
        .keyPort   (keyBus.ctrl)
    );

    // Combinational round
    aesRoundPath roundPath (
        .state     (state),
        .finalRound(finalRound),
        .roundOut  (roundOut)
    );

    // Round key expansion
    aesKeySchedule keySchedule (
        .clk    (clk),
        .rst    (rst),
        .keyPort(keyBus.sched)
    );

endmodule

// File: test/aesCipherTb.sv
`timescale 1ns/1ns

`include "aes_params.svh"

module aesCipherTb
    import aesStatePkg::*;
();

    // Six tests of about AES_ROUNDS+2 cycles, up to 8 stall cycles each, wide margin
    localparam int TIMEOUT_CYCLES = 6 * (`AES_ROUNDS + 2 + 8) * 5;
    localparam int REQUEST_LIMIT  = `AES_ROUNDS + 4;
    localparam logic [31:0] LFSR_SEED = 32'h6d7f0ffb;

    // FIPS-197 vectors
    localparam aesBlockT KEY_C1    = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aesBlockT TEXT_C1   = 128'h00112233445566778899aabbccddeeff;
    localparam aesBlockT CIPHER_C1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aesBlockT KEY_B     = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam aesBlockT TEXT_B    = 128'h3243f6a8885a308d313198a2e0370734;
    localparam aesBlockT CIPHER_B  = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam aesBlockT CIPHER_ZERO = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic        clk;
    logic        rst;
    logic        inValid;
    aesBlockT    plainText;
    aesBlockT    cipherKey;
    logic        outReady;
    logic        inReady;
    logic        outValid;
    aesBlockT    cipherText;
    logic [31:0] lfsrState;
    int          valueErrors;
    int          otherErrors;
    int          cycleCount = 0;

    aesCipherTop UUT (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .plainText (plainText),
        .cipherKey (cipherKey),
        .outReady  (outReady),
        .inReady   (inReady),
        .outValid  (outValid),
        .cipherText(cipherText)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run hung and was stopped after %0d cycles", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] current);
        logic feedback;
        feedback = current[31] ^ current[21] ^ current[1] ^ current[0];
        return {current[30:0], feedback};
    endfunction

    task automatic takeRandomBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic checkBlock(input string testName, input aesBlockT expected,
                              input aesBlockT actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %h, got %h", testName, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input string testName, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %b, got %b", testName, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string testName, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("[FAIL] %s: expected %0d, got %0d", testName, expected, actual);
            valueErrors++;
        end
    endtask

    // Holds the request until accepted; returns just after the accept edge, inValid still high
    task automatic offerBlock(input string testName, input aesBlockT key, input aesBlockT text);
        int waitCycles;
        waitCycles = 0;
        inValid = 1'b1;
        cipherKey = key;
        plainText = text;
        @(negedge clk);
        while (inReady !== 1'b1 && waitCycles < REQUEST_LIMIT)
        begin
            @(posedge clk);
            @(negedge clk);
            waitCycles++;
        end
        if (inReady !== 1'b1)
        begin
            $display("%s: the core never became ready to take the block", testName);
            otherErrors++;
        end
        @(posedge clk);
        #2;
    endtask

    // Counts edges after the accept edge; returns at the falling edge where outValid is seen
    task automatic waitResult(input string testName, output int edges);
        edges = 0;
        @(negedge clk);
        while (outValid !== 1'b1 && edges < REQUEST_LIMIT)
        begin
            @(posedge clk);
            @(negedge clk);
            edges++;
        end
        if (outValid !== 1'b1)
        begin
            $display("%s: no result appeared within %0d cycles", testName, REQUEST_LIMIT);
            otherErrors++;
        end
    endtask

    task automatic encryptBlock(input string testName, input aesBlockT key, input aesBlockT text,
                                output aesBlockT result, output int latency);
        offerBlock(testName, key, text);
        inValid = 1'b0;
        waitResult(testName, latency);
        result = cipherText;
    endtask

    // Delivery edge with outReady high, then outValid must drop
    task automatic takeResult(input string testName);
        @(posedge clk);
        #2;
        @(negedge clk);
        checkFlag({testName, " outValid after delivery"}, 1'b0, outValid);
        @(posedge clk);
        #2;
    endtask

    task automatic testAfterReset();
        @(negedge clk);
        checkFlag("reset outValid", 1'b0, outValid);
        checkFlag("reset inReady", 1'b1, inReady);
        @(posedge clk);
        #2;
    endtask

    task automatic testKnownVector(input string testName, input aesBlockT key,
                                   input aesBlockT text, input aesBlockT expected);
        aesBlockT result;
        int       latency;
        encryptBlock(testName, key, text, result, latency);
        checkBlock(testName, expected, result);
        checkCount({testName, " latency"}, `AES_ROUNDS, latency);
        takeResult(testName);
    endtask

    task automatic testBackPressure();
        aesBlockT result;
        int       latency;
        int       stall;
        takeRandomBits(3, stall);
        $display("Back-pressure stall of %0d cycles", stall);
        outReady = 1'b0;
        encryptBlock("back-pressure", KEY_B, TEXT_B, result, latency);
        checkBlock("back-pressure result", CIPHER_B, result);
        checkFlag("back-pressure inReady", 1'b0, inReady);
        for (int i = 0; i < stall; i++)
        begin
            @(posedge clk);
            @(negedge clk);
            checkFlag("back-pressure outValid", 1'b1, outValid);
            checkFlag("back-pressure inReady", 1'b0, inReady);
            checkBlock("back-pressure held", CIPHER_B, cipherText);
        end
        @(posedge clk);
        #2;
        outReady = 1'b1;
        @(negedge clk);
        checkFlag("back-pressure outValid", 1'b1, outValid);
        checkBlock("back-pressure held", CIPHER_B, cipherText);
        takeResult("back-pressure");
    endtask

    task automatic testBackToBack();
        int latency;
        offerBlock("back-to-back first", KEY_C1, TEXT_C1);
        // Second block waits on the bus while the first runs
        cipherKey = KEY_B;
        plainText = TEXT_B;
        waitResult("back-to-back first", latency);
        checkBlock("back-to-back first", CIPHER_C1, cipherText);
        checkFlag("back-to-back inReady on delivery", 1'b1, inReady);
        @(posedge clk);
        #2;
        inValid = 1'b0;
        waitResult("back-to-back second", latency);
        checkBlock("back-to-back second", CIPHER_B, cipherText);
        checkCount("back-to-back second latency", `AES_ROUNDS, latency);
        takeResult("back-to-back");
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        plainText = '0;
        cipherKey = '0;
        outReady = 1'b0;
        lfsrState = LFSR_SEED;
        valueErrors = 0;
        otherErrors = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        outReady = 1'b1;

        testAfterReset();
        testKnownVector("FIPS-197 C.1", KEY_C1, TEXT_C1, CIPHER_C1);
        testKnownVector("FIPS-197 B", KEY_B, TEXT_B, CIPHER_B);
        testKnownVector("all-zero", '0, '0, CIPHER_ZERO);
        testBackPressure();
        testBackToBack();

        $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: aesCipher.f
+incdir+logic
logic/aesStatePkg.sv
logic/aesKeyPkg.sv
logic/aesKeyIf.sv
logic/aesSbox.sv
logic/mixColumns.sv
logic/aesRoundPath.sv
logic/aesKeySchedule.sv
logic/aesStateUnit.sv
logic/aesCipherTop.sv
test/aesCipherTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the AES testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module aesCipherTb -f aesCipher.f -o aesCipherSim \
    && ./obj_dir/aesCipherSim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
